// ==== Makefile ====
# Verilator flow for the PS/2 keyboard front end
TOP = tb_ps2_keyb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// ==== files.f ====
ps2_pkg.sv
ps2_idle_timer.sv
ps2_rx_fsm.sv
ps2_frame_shift.sv
ps2_xt_translate.sv
ps2_scan_assembler.sv
ps2_keyb.sv
ps2_keyb_properties.sv
tb_ps2_keyb.sv

// ==== ps2_frame_shift.sv ====
// PS/2 frame shift register and bit counter with frame-complete and watchdog clear

`timescale 1ns/1ps

module ps2_frame_shift (
  input  logic       clk,
  input  logic       reset,
  input  logic       shift_en,    // Falling clock marker
  input  logic       data_s,      // Synchronized data line
  input  logic       line_idle,   // Watchdog, drops a partial frame
  output logic       frame_done,  // High one cycle at count 11
  output logic [7:0] code         // Data byte of the frame
);

  logic [ps2_pkg::FRAME_BITS-1:0] frame;
  logic [3:0]                     bit_count;

  // Bits arrive LSB first, so new bits enter at the top
  always_ff @(posedge clk)
  begin
    if (reset)
      frame <= '0;
    else if (shift_en)
      frame <= {data_s, frame[ps2_pkg::FRAME_BITS-1:1]};
  end

  // ------------------------------
  // Bit counter
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || frame_done || line_idle)
      bit_count <= 4'd0;             // Frame taken or abandoned
    else if (shift_en)
      bit_count <= bit_count + 4'd1;
  end

  assign frame_done = (bit_count == 4'(ps2_pkg::FRAME_BITS));
  assign code       = frame[8:1];    // Skip start bit, drop parity and stop

endmodule

// ==== ps2_idle_timer.sv ====
// Saturating idle timer that flags a quiet PS/2 line

`timescale 1ns/1ps

module ps2_idle_timer #(
  parameter int TIMEOUT_CYCLES = 1920,  // 60 us at 32 MHz
  parameter int TIMER_BITS     = 11
) (
  input  logic clk,
  input  logic timer_en,     // Low restarts the count
  output logic timeout_hit   // Level, holds while saturated
);

  localparam logic [TIMER_BITS-1:0] LAST_COUNT = TIMER_BITS'(TIMEOUT_CYCLES - 1);

  logic [TIMER_BITS-1:0] count;

  assign timeout_hit = (count == LAST_COUNT);

  always_ff @(posedge clk)
  begin
    if (!timer_en)
      count <= '0;                  // Restart at every line edge
    else if (!timeout_hit)
      count <= count + 1'b1;        // Stop at the limit
  end

endmodule

// ==== ps2_keyb.sv ====
// Top level of the PS/2 receive front end: FSM, idle timer, frame shift, XT table, assembler

`timescale 1ns/1ps

module ps2_keyb #(
  parameter int TIMEOUT_CYCLES  = 1920,  // 60 us at 32 MHz
  parameter int TIMER_BITS      = 11,
  parameter int TRAP_SHIFT_KEYS = 0
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,     // Keyboard clock line
  input  logic                ps2_data,    // Keyboard data line
  output ps2_pkg::scan_word_t scancode,    // Set 1 byte
  output logic                scan_valid   // New scancode strobe
);

  logic       shift_en;
  logic       data_s;
  logic       timer_en;
  logic       line_idle;
  logic       timeout_hit;
  logic       frame_done;
  logic [7:0] code;
  logic [6:0] xt_code;

  // ------------------------------
  // Line tracking and watchdog
  // ------------------------------
  ps2_rx_fsm rx_fsm_i (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .timeout_hit (timeout_hit),
    .shift_en    (shift_en),
    .data_s      (data_s),
    .timer_en    (timer_en),
    .line_idle   (line_idle)
  );

  ps2_idle_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .TIMER_BITS     (TIMER_BITS)
  ) idle_timer_i (
    .clk         (clk),
    .timer_en    (timer_en),
    .timeout_hit (timeout_hit)
  );

  // ------------------------------
  // Data path
  // ------------------------------
  ps2_frame_shift frame_shift_i (
    .clk        (clk),
    .reset      (reset),
    .shift_en   (shift_en),
    .data_s     (data_s),
    .line_idle  (line_idle),
    .frame_done (frame_done),
    .code       (code)
  );

  ps2_xt_translate xt_translate_i (
    .at_code (code[6:0]),  // Bit 7 codes bypass the table
    .xt_code (xt_code)
  );

  ps2_scan_assembler #(
    .TRAP_SHIFT_KEYS (TRAP_SHIFT_KEYS)
  ) scan_assembler_i (
    .clk        (clk),
    .reset      (reset),
    .frame_done (frame_done),
    .code       (code),
    .xt_code    (xt_code),
    .scancode   (scancode),
    .scan_valid (scan_valid)
  );

endmodule

// ==== ps2_keyb_properties.sv ====
// Concurrent assertions on the PS/2 front end outputs, bit counter and receive FSM

`timescale 1ns/1ps

module ps2_keyb_properties (
  input logic               clk,
  input logic               reset,
  input logic               scan_valid,
  input logic               frame_done,
  input logic [7:0]         code,
  input logic [3:0]         bit_count,
  input ps2_pkg::rx_state_t state
);

  // Strobe is a single cycle
  valid_single: assert property (@(posedge clk) disable iff (reset) scan_valid |=> !scan_valid)
    else $error("scan_valid high two cycles in a row");

  valid_after_reset: assert property (@(posedge clk) reset |=> !scan_valid)
    else $error("scan_valid high right after reset");

  count_bound: assert property (@(posedge clk) disable iff (reset)
    bit_count <= 4'(ps2_pkg::FRAME_BITS))
    else $error("bit count beyond frame length");

  // A pulse needs a finished frame one cycle before
  valid_needs_frame: assert property (@(posedge clk) disable iff (reset)
    scan_valid |-> $past(frame_done))
    else $error("scan_valid without a finished frame");

  // Prefix and zero codes stay silent
  silent_codes: assert property (@(posedge clk) disable iff (reset)
    (frame_done && ((code == ps2_pkg::RELEASE_CODE) || (code == 8'h00))) |=> !scan_valid)
    else $error("scan_valid after a break prefix or zero code");

  // Frame ends inside the low phase of its stop bit
  done_in_low: assert property (@(posedge clk) disable iff (reset)
    frame_done |-> (state == ps2_pkg::clk_low))
    else $error("frame completed outside the clock-low wait");

endmodule

bind ps2_keyb ps2_keyb_properties props_i (
  .clk        (clk),
  .reset      (reset),
  .scan_valid (scan_valid),
  .frame_done (frame_done),
  .code       (code),
  .bit_count  (frame_shift_i.bit_count),
  .state      (rx_fsm_i.state)
);

// ==== ps2_pkg.sv ====
// Frame constants, special scan codes, receive state type and output byte union

package ps2_pkg;

  // ------------------------------
  // Frame format
  // ------------------------------
  localparam int FRAME_BITS = 11;  // Start, 8 data, parity, stop

  // ------------------------------
  // Special set 2 codes
  // ------------------------------
  localparam logic [7:0] RELEASE_CODE     = 8'hf0;  // Break prefix
  localparam logic [7:0] LEFT_SHIFT_CODE  = 8'h12;
  localparam logic [7:0] RIGHT_SHIFT_CODE = 8'h59;

  // Receive FSM states, follows the PS/2 clock level
  typedef enum logic [1:0] {
    clk_high  = 2'd0,  // Waiting for falling clock
    fall_mark = 2'd1,  // One cycle, data sampled here
    clk_low   = 2'd2,  // Waiting for rising clock
    rise_mark = 2'd3   // One cycle, timer restart
  } rx_state_t;

  // Output byte, either passed through raw or built from break flag plus XT code
  typedef union packed {
    logic [7:0] raw;     // Extended codes such as E0, E1
    struct packed {
      logic       brk;      // Key released
      logic [6:0] xt_code;  // Set 1 make code
    } fields;
  } scan_word_t;

endpackage

// ==== ps2_rx_fsm.sv ====
// PS/2 line synchronizers and clock-edge tracking FSM with shift strobe and timer enable

`timescale 1ns/1ps

module ps2_rx_fsm (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,      // Asynchronous, idle high
  input  logic ps2_data,     // Asynchronous, idle high
  input  logic timeout_hit,  // From idle timer
  output logic shift_en,     // One-cycle pulse per falling clock
  output logic data_s,       // Synchronized data bit
  output logic timer_en,     // High while waiting on a level
  output logic line_idle     // Watchdog clear for the bit counter
);

  logic ps2_clk_s;
  logic ps2_data_s;
  ps2_pkg::rx_state_t state;
  ps2_pkg::rx_state_t state_next;

  // ------------------------------
  // Input registers
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ps2_clk_s  <= 1'b1;  // Idle level
      ps2_data_s <= 1'b1;
    end
    else
    begin
      ps2_clk_s  <= ps2_clk;
      ps2_data_s <= ps2_data;
    end
  end

  // ------------------------------
  // Edge tracking
  // ------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      ps2_pkg::clk_high:  if (!ps2_clk_s) state_next = ps2_pkg::fall_mark;
      ps2_pkg::fall_mark: state_next = ps2_pkg::clk_low;   // Single cycle
      ps2_pkg::clk_low:   if (ps2_clk_s) state_next = ps2_pkg::rise_mark;
      ps2_pkg::rise_mark: state_next = ps2_pkg::clk_high;  // Single cycle
      default:            state_next = ps2_pkg::clk_high;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::clk_high;
    else
      state <= state_next;
  end

  assign shift_en = (state == ps2_pkg::fall_mark);
  assign data_s   = ps2_data_s;
  // Markers drop the enable, so the count restarts at each edge
  assign timer_en = (state == ps2_pkg::clk_high) || (state == ps2_pkg::clk_low);
  // Only a quiet line resting high counts as idle
  assign line_idle = timeout_hit && (state == ps2_pkg::clk_high) && ps2_clk_s;

endmodule

// ==== ps2_scan_assembler.sv ====
// Break-prefix hold, shift-key trap and registered scan code output

`timescale 1ns/1ps

module ps2_scan_assembler #(
  parameter int TRAP_SHIFT_KEYS = 0  // 1 hides both shift keys
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                frame_done,  // Frame complete, one cycle
  input  logic [7:0]          code,        // Raw set 2 byte
  input  logic [6:0]          xt_code,     // Translated low bits
  output ps2_pkg::scan_word_t scancode,
  output logic                scan_valid   // One-cycle strobe
);

  logic brk_hold;   // F0 seen, waiting for its key
  logic trap_hit;

  assign trap_hit = (TRAP_SHIFT_KEYS != 0) &&
                    ((code == ps2_pkg::LEFT_SHIFT_CODE) || (code == ps2_pkg::RIGHT_SHIFT_CODE));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      scancode   <= '0;
      scan_valid <= 1'b0;
      brk_hold   <= 1'b0;
    end
    else
    begin
      scan_valid <= 1'b0;                 // Strobe by default low
      if (frame_done)
      begin
        if (code == ps2_pkg::RELEASE_CODE)
          brk_hold <= 1'b1;               // Merged into next code
        else if ((code != 8'h00) && !trap_hit)
        begin
          scan_valid <= 1'b1;
          if (code[7])
            scancode.raw <= code;         // E0, E1 keep the hold pending
          else
          begin
            scancode.fields.brk     <= brk_hold;
            scancode.fields.xt_code <= xt_code;
            brk_hold                <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== ps2_trace.txt ====
# name  data(hex)  bits_sent  gap_cycles  expect_valid  expected_scancode(hex)
# Expected scancode is the held output after the frame, unchanged when no pulse
make_a         1c  11   30  1  1e
brk_prefix     f0  11   30  0  1e
brk_a          1c  11   30  1  9e
brk_prefix2    f0  11   30  0  9e
ext_e0         e0  11   30  1  e0
brk_enter      5a  11   30  1  9c
trap_left      12  11   30  0  9c
trap_right     59  11   30  0  9c
zero_code      00  11   30  0  9c
partial        3a   5  300  0  9c
after_partial  29  11   30  1  39
b2b_1          16  11    2  1  02
b2b_2          1e  11    2  1  03
b2b_3          26  11    2  1  04
b2b_brk        f0  11    2  0  04
b2b_trap       12  11    2  0  04
b2b_key        1c  11    2  1  9e
b2b_esc        76  11    2  1  01

// ==== ps2_xt_translate.sv ====
// Lookup table from AT set 2 scan codes to XT set 1 scan codes

`timescale 1ns/1ps

module ps2_xt_translate (
  input  logic [6:0] at_code,  // Set 2 code, bit 7 handled elsewhere
  output logic [6:0] xt_code   // Set 1 make code, zero if unknown
);

  always_comb
  begin
    case (at_code)
      7'h76: xt_code = 7'h01;  // Esc
      7'h16: xt_code = 7'h02;  // Digit row
      7'h1e: xt_code = 7'h03;
      7'h26: xt_code = 7'h04;
      7'h25: xt_code = 7'h05;
      7'h2e: xt_code = 7'h06;
      7'h36: xt_code = 7'h07;
      7'h3d: xt_code = 7'h08;
      7'h3e: xt_code = 7'h09;
      7'h46: xt_code = 7'h0a;
      7'h45: xt_code = 7'h0b;
      7'h4e: xt_code = 7'h0c;
      7'h55: xt_code = 7'h0d;
      7'h66: xt_code = 7'h0e;  // Backspace
      7'h0d: xt_code = 7'h0f;  // Tab
      7'h15: xt_code = 7'h10;  // Q row
      7'h1d: xt_code = 7'h11;
      7'h24: xt_code = 7'h12;
      7'h2d: xt_code = 7'h13;
      7'h2c: xt_code = 7'h14;
      7'h35: xt_code = 7'h15;
      7'h3c: xt_code = 7'h16;
      7'h43: xt_code = 7'h17;
      7'h44: xt_code = 7'h18;
      7'h4d: xt_code = 7'h19;
      7'h54: xt_code = 7'h1a;
      7'h5b: xt_code = 7'h1b;
      7'h5a: xt_code = 7'h1c;  // Enter
      7'h14: xt_code = 7'h1d;  // Left ctrl
      7'h1c: xt_code = 7'h1e;  // A row
      7'h1b: xt_code = 7'h1f;
      7'h23: xt_code = 7'h20;
      7'h2b: xt_code = 7'h21;
      7'h34: xt_code = 7'h22;
      7'h33: xt_code = 7'h23;
      7'h3b: xt_code = 7'h24;
      7'h42: xt_code = 7'h25;
      7'h4b: xt_code = 7'h26;
      7'h4c: xt_code = 7'h27;
      7'h52: xt_code = 7'h28;
      7'h0e: xt_code = 7'h29;  // Back tick
      7'h12: xt_code = 7'h2a;  // Left shift
      7'h5d: xt_code = 7'h2b;
      7'h1a: xt_code = 7'h2c;  // Z row
      7'h22: xt_code = 7'h2d;
      7'h21: xt_code = 7'h2e;
      7'h2a: xt_code = 7'h2f;
      7'h32: xt_code = 7'h30;
      7'h31: xt_code = 7'h31;
      7'h3a: xt_code = 7'h32;
      7'h41: xt_code = 7'h33;
      7'h49: xt_code = 7'h34;
      7'h4a: xt_code = 7'h35;
      7'h59: xt_code = 7'h36;  // Right shift
      7'h11: xt_code = 7'h38;  // Left alt
      7'h29: xt_code = 7'h39;  // Space
      7'h58: xt_code = 7'h3a;  // Caps lock
      // Function keys, F7 is 83 and passes through raw
      7'h05: xt_code = 7'h3b;
      7'h06: xt_code = 7'h3c;
      7'h04: xt_code = 7'h3d;
      7'h0c: xt_code = 7'h3e;
      7'h03: xt_code = 7'h3f;
      7'h0b: xt_code = 7'h40;
      7'h0a: xt_code = 7'h42;
      7'h01: xt_code = 7'h43;
      7'h09: xt_code = 7'h44;
      7'h78: xt_code = 7'h57;  // F11
      7'h07: xt_code = 7'h58;  // F12
      7'h77: xt_code = 7'h45;  // Num lock
      7'h7e: xt_code = 7'h46;  // Scroll lock
      default: xt_code = 7'h00;
    endcase
  end

endmodule

// ==== tb_ps2_keyb.sv ====
// Testbench for the PS/2 keyboard front end, frames and expected codes read from a trace

`timescale 1ns/1ps

module tb_ps2_keyb;

  localparam int HALF_MIN   = 20;  // PS/2 half-period in system cycles
  localparam int JITTER_MAX = 3;   // Extra cycles per half-period
  localparam int RESET_LEN  = 8;

  logic                clk;
  logic                reset;
  logic                ps2_clk;
  logic                ps2_data;
  ps2_pkg::scan_word_t scancode;
  logic                scan_valid;

  // Trace columns, one entry per test
  string      name_q[$];
  logic [7:0] data_q[$];
  int         nbits_q[$];
  int         gap_q[$];
  int         expv_q[$];
  logic [7:0] exps_q[$];

  int pulse_count;
  int pass_count;
  int fail_count;
  int limit_cycles = 0;  // Set once the trace is loaded

  ps2_keyb #(
    .TIMEOUT_CYCLES  (200),
    .TIMER_BITS      (11),
    .TRAP_SHIFT_KEYS (1)
  ) ps2_keyb_i (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scancode   (scancode),
    .scan_valid (scan_valid)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Count strobes away from the active edge
  always @(negedge clk)
  begin
    if (!reset && scan_valid)
      pulse_count = pulse_count + 1;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;                              // Drive just after the edge
  endtask

  function automatic int half_period();
    return HALF_MIN + int'($urandom % (JITTER_MAX + 1));
  endfunction

  // Start, data LSB first, odd parity, stop; nbits below 11 truncates
  task automatic send_frame(input logic [7:0] data, input int nbits);
    logic [ps2_pkg::FRAME_BITS-1:0] bits;
    int                             i;
    bits = {1'b1, ~^data, data, 1'b0};
    for (i = 0; i < nbits; i++)
    begin
      ps2_data = bits[i];            // Data settles while clock is high
      wait_cycles(half_period());
      ps2_clk = 1'b0;
      wait_cycles(half_period());
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;                 // Back to idle
  endtask

  task automatic load_trace();
    int         fd;
    int         cnt;
    int         nbits;
    int         gap;
    int         expv;
    string      line;
    string      name;
    logic [7:0] data;
    logic [7:0] exps;
    fd = $fopen("ps2_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Error: cannot open ps2_trace.txt");
      fail_count++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#")
        continue;                    // Blank or column notes
      cnt = $sscanf(line, "%s %h %d %d %d %h", name, data, nbits, gap, expv, exps);
      if (cnt == 6)
      begin
        name_q.push_back(name);
        data_q.push_back(data);
        nbits_q.push_back(nbits);
        gap_q.push_back(gap);
        expv_q.push_back(expv);
        exps_q.push_back(exps);
      end
    end
    $fclose(fd);
    if (name_q.size() == 0)
    begin
      $display("Error: trace file holds no tests");
      fail_count++;
    end
  endtask

  // ------------------------------
  // One trace line
  // ------------------------------
  task automatic run_test(input int idx);
    ps2_pkg::scan_word_t expected;
    bit                  ok;
    string               tag;
    expected.raw = exps_q[idx];
    ok           = 1'b1;
    tag          = "";
    pulse_count  = 0;
    send_frame(data_q[idx], nbits_q[idx]);
    wait_cycles(gap_q[idx]);
    if (pulse_count != expv_q[idx])
    begin
      $display("Test %s: expected %0d scan_valid pulse(s) but saw %0d",
               name_q[idx], expv_q[idx], pulse_count);
      ok = 1'b0;
    end
    if (scancode.raw !== expected.raw)
    begin
      $display("Mismatch in test %s: scancode = %h, expected %h",
               name_q[idx], scancode.raw, expected.raw);
      ok = 1'b0;
    end
    if (data_q[idx] == ps2_pkg::RELEASE_CODE)
      tag = "  (break prefix)";
    if (ok)
    begin
      pass_count++;
      $display("Test %-14s passed  data %h -> scancode %h brk %0d xt %h%s", name_q[idx],
               data_q[idx], scancode.raw, expected.fields.brk, expected.fields.xt_code, tag);
    end
    else
    begin
      fail_count++;
      $display("Test %-14s failed", name_q[idx]);
    end
  endtask

  // Hang guard sized from the trace length
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    int max_gap;
    int idx;
    clk         = 1'b0;
    reset       = 1'b1;
    ps2_clk     = 1'b1;              // Lines idle high
    ps2_data    = 1'b1;
    pulse_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    void'($urandom(32'h5aa2));
    load_trace();
    max_gap = 0;
    foreach (gap_q[i])
      if (gap_q[i] > max_gap)
        max_gap = gap_q[i];
    // Longest frame plus gap per line, one spare line for reset
    limit_cycles = (gap_q.size() + 1) *
                   (2 * ps2_pkg::FRAME_BITS * (HALF_MIN + JITTER_MAX) + max_gap) + RESET_LEN;
    repeat (RESET_LEN) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles(4);
    for (idx = 0; idx < name_q.size(); idx++)
      run_test(idx);
    $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
